/* read_compare.f */
+incdir+tests
design/rc_cfg_pkg.sv
design/rc_types_pkg.sv
design/pattern_lfsr.sv
design/addr_tracker.sv
design/bit_compare.sv
design/fail_capture.sv
design/compare_credit.sv
design/read_compare_top.sv
tests/tb_read_compare.sv

/* Bender.yml */
package:
  name: read_compare

sources:
  - design/rc_cfg_pkg.sv
  - design/rc_types_pkg.sv
  - design/pattern_lfsr.sv
  - design/addr_tracker.sv
  - design/bit_compare.sv
  - design/fail_capture.sv
  - design/compare_credit.sv
  - design/read_compare_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/tb_read_compare.sv

/* tests/read_compare_tests.svh */
//////////////////////////////
// Directed tests and stimulus tasks
//////////////////////////////
`ifndef READ_COMPARE_TESTS_SVH
`define READ_COMPARE_TESTS_SVH

function automatic logic [ADDR_WIDTH-1:0] random_word_addr();
   logic [31:0] r;
   r = $random(seed);
   return {r[ADDR_WIDTH-1:2], 2'b00};
endfunction

// Burst length 1 to 8
function automatic int random_count();
   logic [31:0] r;
   r = $random(seed);
   return 1 + int'(r[2:0]);
endfunction

task automatic push_cmd(input logic [ADDR_WIDTH-1:0] addr, input int count);
   cmd_push       = 1'b1;
   cmd.addr       = addr;
   cmd.burstcount = count[SIZE_WIDTH-1:0];
   next_cycle();
   cmd_push = 1'b0;
endtask

task automatic pulse_req(input int pulses);
   repeat (pulses) begin
      cmp_req = 1'b1;
      next_cycle();
   end
   cmp_req = 1'b0;
endtask

// Return model data, one bit flipped at err_beat, optional noise in disabled lanes
task automatic send_beats(input int count, input int err_beat, input bit noise_off_lanes,
                          output logic [DATA_WIDTH-1:0] err_exp,
                          output logic [DATA_WIDTH-1:0] err_act);
   logic [DATA_WIDTH-1:0] data;
   logic [BE_WIDTH-1:0]   be;
   logic [DATA_WIDTH-1:0] mask;
   logic [DATA_WIDTH-1:0] sent;
   int                    lane;
   err_exp = '0;
   err_act = '0;
   for (int k = 0; k < count; k++) begin
      model_take(data, be);
      mask = lane_mask(be);
      sent = noise_off_lanes ? (data ^ ~mask) : data;
      if (k == err_beat) begin
         // Flip bit 3 of the lowest enabled lane, as the BE pattern is never zero
         lane = 0;
         for (int i = BE_WIDTH - 1; i >= 0; i--) begin
            if (be[i]) begin
               lane = i;
            end
         end
         sent[lane*BYTE_SIZE + 3] = ~sent[lane*BYTE_SIZE + 3];
         err_exp = data & mask;
         err_act = sent & mask;
      end
      beat.valid = 1'b1;
      beat.data  = sent;
      next_cycle();
   end
   beat.valid = 1'b0;
   exp_compares += count;
endtask

task automatic run_burst(input logic [ADDR_WIDTH-1:0] addr, input int count, input int err_beat,
                         input bit noise_off_lanes,
                         output logic [DATA_WIDTH-1:0] err_exp,
                         output logic [DATA_WIDTH-1:0] err_act);
   push_cmd(addr, count);
   pulse_req(count);
   send_beats(count, err_beat, noise_off_lanes, err_exp, err_act);
endtask

// Bounded wait for the compare counter to catch up with the beats sent
task automatic wait_compares();
   int cycles;
   cycles = 0;
   while (compare_count != exp_compares && cycles < 20) begin
      next_cycle();
      cycles++;
   end
   if (compare_count != exp_compares) begin
      $display("Timeout: compare_count stuck at %0d while waiting for %0d",
               compare_count, exp_compares);
      $display("tests failed");
      $fatal(1, "compare wait timed out");
   end
   idle(2);
endtask

//////////////////////////////
// Tests
//////////////////////////////

task automatic test_reset_state();
   idle(4);
   check_value("reset_state pnf_per_bit", {DATA_WIDTH{1'b1}}, pnf_per_bit);
   check_value("reset_state captured_first_fail", 0, captured_first_fail);
   check_value("reset_state fail_count", 0, fail_count);
   check_value("reset_state compare_count", 0, compare_count);
   check_value("reset_state cmp_queue_empty", 1, cmp_queue_empty);
   check_value("reset_state cmp_queue_full", 0, cmp_queue_full);
endtask

task automatic test_clean_readback();
   logic [DATA_WIDTH-1:0] unused_exp;
   logic [DATA_WIDTH-1:0] unused_act;
   idle(4);
   pnf_watch = 1'b1;
   for (int i = 0; i < CLEAN_BURSTS; i++) begin
      run_burst(random_word_addr(), random_count(), -1, 1'b0, unused_exp, unused_act);
      idle(3);
   end
   wait_compares();
   pnf_watch = 1'b0;
   check_value("clean_readback compare_count", exp_compares, compare_count);
   check_value("clean_readback fail_count", 0, fail_count);
endtask

task automatic test_bit_error();
   logic [DATA_WIDTH-1:0] exp_m;
   logic [DATA_WIDTH-1:0] act_m;
   logic [DATA_WIDTH-1:0] exp_pnf;
   logic [DATA_WIDTH-1:0] unused_exp;
   logic [DATA_WIDTH-1:0] unused_act;
   logic [ADDR_WIDTH-1:0] addr;
   logic [ADDR_WIDTH-1:0] fail_addr;
   idle(4);
   addr      = random_word_addr();
   fail_addr = addr + ADDR_WIDTH'(4 * 2);
   run_burst(addr, 5, 2, 1'b0, exp_m, act_m);
   exp_fails++;
   wait_compares();
   // Only the flipped bit reads as a fail
   exp_pnf = ~(exp_m ^ act_m);
   check_value("bit_error pnf_per_bit", exp_pnf, low_pnf);
   check_value("bit_error captured_first_fail", 1, captured_first_fail);
   check_value("bit_error first_fail.addr", fail_addr, first_fail.addr);
   check_value("bit_error first_fail.expected", exp_m, first_fail.expected);
   check_value("bit_error first_fail.actual", act_m, first_fail.actual);
   check_value("bit_error fail_count", exp_fails, fail_count);
   // A second failure counts but keeps the first record
   run_burst(random_word_addr(), 3, 0, 1'b0, unused_exp, unused_act);
   exp_fails++;
   wait_compares();
   check_value("bit_error second fail_count", exp_fails, fail_count);
   check_value("bit_error held addr", fail_addr, first_fail.addr);
   check_value("bit_error held expected", exp_m, first_fail.expected);
   check_value("bit_error held actual", act_m, first_fail.actual);
endtask

task automatic test_masked_lanes();
   logic [DATA_WIDTH-1:0] unused_exp;
   logic [DATA_WIDTH-1:0] unused_act;
   idle(4);
   run_burst(random_word_addr(), 8, -1, 1'b1, unused_exp, unused_act);
   wait_compares();
   check_value("masked_lanes compare_count", exp_compares, compare_count);
   check_value("masked_lanes fail_count", exp_fails, fail_count);
endtask

task automatic test_queue_full();
   logic [DATA_WIDTH-1:0] unused_exp;
   logic [DATA_WIDTH-1:0] unused_act;
   idle(4);
   pulse_req(CMP_QUEUE_DEPTH);
   idle(2);
   check_value("queue_full cmp_queue_full", 1, cmp_queue_full);
   check_value("queue_full cmp_queue_empty", 0, cmp_queue_empty);
   push_cmd(random_word_addr(), CMP_QUEUE_DEPTH / 2);
   push_cmd(random_word_addr(), CMP_QUEUE_DEPTH / 2);
   send_beats(CMP_QUEUE_DEPTH, -1, 1'b0, unused_exp, unused_act);
   wait_compares();
   check_value("queue_full drained empty", 1, cmp_queue_empty);
   check_value("queue_full drained full", 0, cmp_queue_full);
   check_value("queue_full fail_count", exp_fails, fail_count);
endtask

task automatic test_enable_low();
   logic [DATA_WIDTH-1:0] unused_exp;
   logic [DATA_WIDTH-1:0] unused_act;
   idle(4);
   enable = 1'b0;
   for (int i = 0; i < 4; i++) begin
      beat.valid = 1'b1;
      beat.data  = $random(seed);
      next_cycle();
   end
   beat.valid = 1'b0;
   idle(6);
   check_value("enable_low compare_count", exp_compares, compare_count);
   check_value("enable_low fail_count", exp_fails, fail_count);
   check_value("enable_low cmp_queue_empty", 1, cmp_queue_empty);
   enable = 1'b1;
   idle(2);
   run_burst(random_word_addr(), 4, -1, 1'b0, unused_exp, unused_act);
   wait_compares();
   check_value("enable_low resumed compare_count", exp_compares, compare_count);
   check_value("enable_low resumed fail_count", exp_fails, fail_count);
endtask

`endif

/* tests/tb_read_compare.sv */
//////////////////////////////
// Read compare testbench
// Clock, reset, DUT, reference pattern model, checks, watchdog
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module tb_read_compare;
   import rc_cfg_pkg::*;
   import rc_types_pkg::*;

   localparam time CLK_PERIOD    = 100ns;
   localparam time DRIVE_DELAY   = 10ns;
   localparam int  RESET_CYCLES  = 3;
   localparam int  CLEAN_BURSTS  = 6;
   // Rough cycle cost of each test, summed for the watchdog
   localparam int  TEST_CYCLES   = RESET_CYCLES + 10 + CLEAN_BURSTS * 25 + 30 + 80 + 40 + 60 + 50;
   localparam int  MARGIN_CYCLES = 200;

   logic                  clk;
   logic                  reset_n;
   logic                  enable;
   logic                  cmd_push;
   rd_cmd_t               cmd;
   logic                  cmp_req;
   rd_beat_t              beat;
   logic [DATA_WIDTH-1:0] pnf_per_bit;
   logic                  cmp_queue_full;
   logic                  cmp_queue_empty;
   logic                  captured_first_fail;
   fail_info_t            first_fail;
   logic [STAT_WIDTH-1:0] fail_count;
   logic [STAT_WIDTH-1:0] compare_count;

   // Reference pattern state and expected statistics
   logic [DATA_WIDTH-1:0] ref_data;
   logic [BE_WIDTH-1:0]   ref_be;
   integer                seed;
   int                    exp_compares;
   int                    exp_fails;
   logic                  pnf_watch;
   logic [DATA_WIDTH-1:0] low_pnf;

   read_compare_top u_dut (
      .clk                 (clk),
      .reset_n             (reset_n),
      .enable              (enable),
      .cmd_push            (cmd_push),
      .cmd                 (cmd),
      .cmp_req             (cmp_req),
      .beat                (beat),
      .pnf_per_bit         (pnf_per_bit),
      .cmp_queue_full      (cmp_queue_full),
      .cmp_queue_empty     (cmp_queue_empty),
      .captured_first_fail (captured_first_fail),
      .first_fail          (first_fail),
      .fail_count          (fail_count),
      .compare_count       (compare_count)
   );

   initial begin
      clk = 1'b0;
      forever #(CLK_PERIOD / 2) clk = ~clk;
   end

   //////////////////////////////
   // Checking and model helpers
   //////////////////////////////

   task automatic check_value(input string name, input logic [63:0] expected,
                              input logic [63:0] actual);
      if (expected !== actual) begin
         $display("** Error %s: expected %0h, actual %0h", name, expected, actual);
         $display("tests failed");
         $fatal(1, "check %s stopped the run", name);
      end
   endtask

   // 32-bit Fibonacci step, feedback from bits 31, 21, 1, 0
   function automatic logic [DATA_WIDTH-1:0] data_step(input logic [DATA_WIDTH-1:0] d);
      return {d[DATA_WIDTH-2:0], d[31] ^ d[21] ^ d[1] ^ d[0]};
   endfunction

   // 4-bit step, feedback from bits 3 and 2
   function automatic logic [BE_WIDTH-1:0] be_step(input logic [BE_WIDTH-1:0] b);
      return {b[BE_WIDTH-2:0], b[3] ^ b[2]};
   endfunction

   // Each data bit follows the enable of the byte lane it sits in
   function automatic logic [DATA_WIDTH-1:0] lane_mask(input logic [BE_WIDTH-1:0] be);
      logic [DATA_WIDTH-1:0] m;
      for (int i = 0; i < DATA_WIDTH; i++) begin
         m[i] = be[i / BYTE_SIZE];
      end
      return m;
   endfunction

   // Pattern for the next compared beat, then advance
   task automatic model_take(output logic [DATA_WIDTH-1:0] data, output logic [BE_WIDTH-1:0] be);
      data     = ref_data;
      be       = ref_be;
      ref_data = data_step(ref_data);
      ref_be   = be_step(ref_be);
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #(DRIVE_DELAY);
   endtask

   task automatic idle(input int cycles);
      repeat (cycles) next_cycle();
   endtask

   // Stays all ones while only clean data is returned
   // Outside that window the first word with a failing bit is kept
   always @(negedge clk) begin
      if (pnf_watch) begin
         check_value("clean_readback pnf_per_bit", {DATA_WIDTH{1'b1}}, pnf_per_bit);
      end else if ((&low_pnf) && !(&pnf_per_bit)) begin
         low_pnf = pnf_per_bit;
      end
   end

   initial begin
      #((TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD);
      $display("Timeout: the run did not finish within %0d cycles",
               TEST_CYCLES + MARGIN_CYCLES);
      $display("tests failed");
      $fatal(1, "watchdog expired");
   end

   `include "read_compare_tests.svh"

   initial begin
      seed         = 32'h831b8e03;
      reset_n      = 1'b0;
      enable       = 1'b0;
      cmd_push     = 1'b0;
      cmd          = '0;
      cmp_req      = 1'b0;
      beat         = '0;
      ref_data     = DATA_SEED;
      ref_be       = BE_SEED;
      exp_compares = 0;
      exp_fails    = 0;
      pnf_watch    = 1'b0;
      low_pnf      = '1;
      repeat (RESET_CYCLES) @(posedge clk);
      #(DRIVE_DELAY);
      reset_n = 1'b1;
      enable  = 1'b1;

      test_reset_state();
      test_clean_readback();
      test_bit_error();
      test_masked_lanes();
      test_queue_full();
      test_enable_low();

      $display("all tests passed");
      $finish;
   end

endmodule

`default_nettype wire

/* design/read_compare_top.sv */
//////////////////////////////
// Read compare checker top
// Pattern regen, address tracking, compare, capture, credit
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module read_compare_top (
   input  logic                              clk,
   input  logic                              reset_n,
   input  logic                              enable,
   input  logic                              cmd_push,
   input  rc_types_pkg::rd_cmd_t             cmd,
   input  logic                              cmp_req,
   input  rc_types_pkg::rd_beat_t            beat,
   output logic [rc_cfg_pkg::DATA_WIDTH-1:0] pnf_per_bit,
   output logic                              cmp_queue_full,
   output logic                              cmp_queue_empty,
   output logic                              captured_first_fail,
   output rc_types_pkg::fail_info_t          first_fail,
   output logic [rc_cfg_pkg::STAT_WIDTH-1:0] fail_count,
   output logic [rc_cfg_pkg::STAT_WIDTH-1:0] compare_count
);
   import rc_cfg_pkg::*;
   import rc_types_pkg::*;

   logic                       compare_step;
   expect_t                    expected;
   logic [WORD_ADDR_WIDTH-1:0] beat_addr;
   cmp_result_t                result;

   // Both step once per compared beat
   pattern_lfsr u_pattern_lfsr (
      .clk      (clk),
      .reset_n  (reset_n),
      .step     (compare_step),
      .expected (expected)
   );

   addr_tracker u_addr_tracker (
      .clk       (clk),
      .reset_n   (reset_n),
      .cmd_push  (cmd_push),
      .cmd       (cmd),
      .beat_step (compare_step),
      .beat_addr (beat_addr)
   );

   bit_compare u_bit_compare (
      .clk          (clk),
      .reset_n      (reset_n),
      .enable       (enable),
      .beat         (beat),
      .expected     (expected),
      .beat_addr    (beat_addr),
      .compare_step (compare_step),
      .pnf_per_bit  (pnf_per_bit),
      .result       (result)
   );

   fail_capture u_fail_capture (
      .clk                 (clk),
      .reset_n             (reset_n),
      .result              (result),
      .captured_first_fail (captured_first_fail),
      .first_fail          (first_fail),
      .fail_count          (fail_count),
      .compare_count       (compare_count)
   );

   compare_credit u_compare_credit (
      .clk             (clk),
      .reset_n         (reset_n),
      .enable          (enable),
      .cmp_req         (cmp_req),
      .compare_step    (compare_step),
      .cmp_queue_full  (cmp_queue_full),
      .cmp_queue_empty (cmp_queue_empty)
   );

endmodule

`default_nettype wire

/* design/compare_credit.sv */
//////////////////////////////
// Pending compare counter
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module compare_credit (
   input  logic clk,
   input  logic reset_n,
   input  logic enable,
   input  logic cmp_req,
   input  logic compare_step,
   output logic cmp_queue_full,
   output logic cmp_queue_empty
);
   import rc_cfg_pkg::*;

   logic                       req_in;
   logic [CMP_COUNT_WIDTH-1:0] pending;

   assign req_in = enable & cmp_req;

   // Request and compare together cancel out
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         pending <= '0;
      end else begin
         case ({req_in, compare_step})
            2'b10:   pending <= pending + 1'b1;
            2'b01:   pending <= pending - 1'b1;
            default: pending <= pending;
         endcase
      end
   end

   assign cmp_queue_full  = (pending == CMP_COUNT_WIDTH'(CMP_QUEUE_DEPTH));
   assign cmp_queue_empty = (pending == '0);

   // A beat is compared only against an earlier request
   assert property (@(posedge clk) disable iff (!reset_n)
                    (compare_step && !req_in) |-> (pending != '0))
      else $error("compare request counter underflow");

endmodule

`default_nettype wire

/* design/fail_capture.sv */
//////////////////////////////
// Failure capture
// First-failure record, failure and compare counters
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module fail_capture (
   input  logic                              clk,
   input  logic                              reset_n,
   input  rc_types_pkg::cmp_result_t         result,
   output logic                              captured_first_fail,
   output rc_types_pkg::fail_info_t          first_fail,
   output logic [rc_cfg_pkg::STAT_WIDTH-1:0] fail_count,
   output logic [rc_cfg_pkg::STAT_WIDTH-1:0] compare_count
);
   import rc_types_pkg::*;

   logic       fail_flag;
   logic       active_r;
   fail_info_t fail_rec;

   // Any low pnf bit on a compared beat
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         fail_flag <= 1'b0;
         active_r  <= 1'b0;
      end else begin
         fail_flag <= result.active && !(&result.pnf);
         active_r  <= result.active;
      end
   end

   // Record travels alongside the flag
   always_ff @(posedge clk) begin
      fail_rec <= '{expected: result.expected, actual: result.actual, addr: result.addr};
   end

   //////////////////////////////
   // Statistics
   //////////////////////////////

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         captured_first_fail <= 1'b0;
         fail_count          <= '0;
         compare_count       <= '0;
      end else begin
         if (active_r) begin
            compare_count <= compare_count + 1'b1;
         end
         if (fail_flag) begin
            fail_count          <= fail_count + 1'b1;
            captured_first_fail <= 1'b1;
         end
      end
   end

   // Only the first failure is kept, held until reset
   always_ff @(posedge clk) begin
      if (fail_flag && !captured_first_fail) begin
         first_fail <= fail_rec;
      end
   end

endmodule

`default_nettype wire

/* design/bit_compare.sv */
//////////////////////////////
// Per-bit read data compare
// Input pipeline, lane masking, result register
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module bit_compare (
   input  logic                                   clk,
   input  logic                                   reset_n,
   input  logic                                   enable,
   input  rc_types_pkg::rd_beat_t                 beat,
   input  rc_types_pkg::expect_t                  expected,
   input  logic [rc_cfg_pkg::WORD_ADDR_WIDTH-1:0] beat_addr,
   output logic                                   compare_step,
   output logic [rc_cfg_pkg::DATA_WIDTH-1:0]      pnf_per_bit,
   output rc_types_pkg::cmp_result_t              result
);
   import rc_cfg_pkg::*;

   logic                  valid_r1;
   logic                  valid_r2;
   logic [DATA_WIDTH-1:0] data_r1;
   logic [DATA_WIDTH-1:0] data_r2;
   logic [DATA_WIDTH-1:0] bit_mask;
   logic                  active_s3;
   logic [DATA_WIDTH-1:0] pnf_s3;
   logic [DATA_WIDTH-1:0] exp_s3;
   logic [DATA_WIDTH-1:0] act_s3;
   logic [ADDR_WIDTH-1:0] addr_s3;

   // Input pipeline
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         valid_r1 <= 1'b0;
         valid_r2 <= 1'b0;
      end else begin
         valid_r1 <= beat.valid;
         valid_r2 <= valid_r1;
      end
   end

   always_ff @(posedge clk) begin
      data_r1 <= beat.data;
      data_r2 <= data_r1;
   end

   assign compare_step = valid_r2 & enable;

   // Byte enables widened to one bit per data bit
   always_comb begin
      for (int i = 0; i < BE_WIDTH; i++) begin
         bit_mask[i*BYTE_SIZE +: BYTE_SIZE] = {BYTE_SIZE{expected.be[i]}};
      end
   end

   //////////////////////////////
   // Compare stage
   //////////////////////////////

   // Disabled lanes and idle cycles report pass
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         active_s3 <= 1'b0;
         pnf_s3    <= '1;
      end else begin
         active_s3 <= compare_step;
         pnf_s3    <= compare_step ? (~(data_r2 ^ expected.data) | ~bit_mask) : '1;
      end
   end

   always_ff @(posedge clk) begin
      exp_s3  <= expected.data & bit_mask;
      act_s3  <= data_r2 & bit_mask;
      addr_s3 <= {beat_addr, {(ADDR_WIDTH-WORD_ADDR_WIDTH){1'b0}}};
   end

   // Output register
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         result <= '{active: 1'b0, pnf: '1, expected: '0, actual: '0, addr: '0};
      end else begin
         result <= '{active: active_s3, pnf: pnf_s3, expected: exp_s3,
                     actual: act_s3, addr: addr_s3};
      end
   end

   assign pnf_per_bit = result.pnf;

endmodule

`default_nettype wire

/* design/addr_tracker.sv */
//////////////////////////////
// Read address tracker
// Command FIFO and burst FSM giving the word address of each beat
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module addr_tracker (
   input  logic                                   clk,
   input  logic                                   reset_n,
   input  logic                                   cmd_push,
   input  rc_types_pkg::rd_cmd_t                  cmd,
   input  logic                                   beat_step,
   output logic [rc_cfg_pkg::WORD_ADDR_WIDTH-1:0] beat_addr
);
   import rc_cfg_pkg::*;
   import rc_types_pkg::*;

   logic                              push_r;
   rd_cmd_t                           cmd_r;
   rd_cmd_t                           fifo_mem [CMD_FIFO_DEPTH];
   logic [$clog2(CMD_FIFO_DEPTH)-1:0] wr_ptr;
   logic [$clog2(CMD_FIFO_DEPTH)-1:0] rd_ptr;
   logic [$clog2(CMD_FIFO_DEPTH):0]   fifo_count;
   logic                              fifo_empty;
   logic                              fifo_full;
   logic                              fifo_pop;
   rd_cmd_t                           head;
   tracker_state_t                    state;
   logic [WORD_ADDR_WIDTH-1:0]        base_word;
   logic [SIZE_WIDTH-1:0]             beat_idx;
   logic [SIZE_WIDTH-1:0]             beats_left;
   logic                              last_beat;

   //////////////////////////////
   // Command FIFO
   //////////////////////////////

   // Input stage
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         push_r <= 1'b0;
      end else begin
         push_r <= cmd_push;
      end
   end

   always_ff @(posedge clk) begin
      cmd_r <= cmd;
      if (push_r) begin
         fifo_mem[wr_ptr] <= cmd_r;
      end
   end

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         wr_ptr     <= '0;
         rd_ptr     <= '0;
         fifo_count <= '0;
      end else begin
         if (push_r) begin
            wr_ptr <= wr_ptr + 1'b1;
         end
         if (fifo_pop) begin
            rd_ptr <= rd_ptr + 1'b1;
         end
         case ({push_r, fifo_pop})
            2'b10:   fifo_count <= fifo_count + 1'b1;
            2'b01:   fifo_count <= fifo_count - 1'b1;
            default: fifo_count <= fifo_count;
         endcase
      end
   end

   // Depth is a power of two, so the count MSB alone means full
   assign fifo_full  = fifo_count[$clog2(CMD_FIFO_DEPTH)];
   assign fifo_empty = (fifo_count == '0);
   assign head       = fifo_mem[rd_ptr];

   //////////////////////////////
   // Burst FSM
   //////////////////////////////

   assign last_beat = (beats_left == '0);

   // Load on the first non-empty cycle when idle, or straight after the last beat
   assign fifo_pop = !fifo_empty &&
                     ((state == WAIT_CMD) || (beat_step && last_beat));

   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         state      <= WAIT_CMD;
         beat_idx   <= '0;
         beats_left <= '0;
      end else if (fifo_pop) begin
         state      <= WAIT_DATA;
         beat_idx   <= '0;
         beats_left <= head.burstcount - 1'b1;
      end else if (beat_step && (state == WAIT_DATA)) begin
         if (last_beat) begin
            state <= WAIT_CMD;
         end else begin
            beat_idx   <= beat_idx + 1'b1;
            beats_left <= beats_left - 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fifo_pop) begin
         base_word <= head.addr[ADDR_WIDTH-1:ADDR_WIDTH-WORD_ADDR_WIDTH];
      end
   end

   assign beat_addr = base_word + WORD_ADDR_WIDTH'(beat_idx);

   // The source holds no more than the FIFO depth in flight
   assert property (@(posedge clk) disable iff (!reset_n)
                    cmd_push |=> (!fifo_full || fifo_pop))
      else $error("read command FIFO overflow");

   // Every compared beat belongs to a loaded command
   assert property (@(posedge clk) disable iff (!reset_n)
                    beat_step |-> (state == WAIT_DATA))
      else $error("read beat with no pending command");

endmodule

`default_nettype wire

/* design/pattern_lfsr.sv */
//////////////////////////////
// Expected pattern generator
// Data LFSR and byte-enable LFSR
//////////////////////////////
`default_nettype none
`timescale 1ns/10ps

module pattern_lfsr (
   input  logic                  clk,
   input  logic                  reset_n,
   input  logic                  step,
   output rc_types_pkg::expect_t expected
);
   import rc_cfg_pkg::*;

   logic [DATA_WIDTH-1:0] data_lfsr;
   logic [BE_WIDTH-1:0]   be_lfsr;

   // Same seeds as the write generator, so the sequences line up
   // as long as both sides step once per beat
   always_ff @(posedge clk or negedge reset_n) begin
      if (!reset_n) begin
         data_lfsr <= DATA_SEED;
         be_lfsr   <= BE_SEED;
      end else if (step) begin
         // Fibonacci form, feedback enters at bit 0
         data_lfsr <= {data_lfsr[DATA_WIDTH-2:0], ^(data_lfsr & DATA_TAPS)};
         be_lfsr   <= {be_lfsr[BE_WIDTH-2:0], ^(be_lfsr & BE_TAPS)};
      end
   end

   // Current state is the pattern for the beat under compare
   assign expected.data = data_lfsr;
   assign expected.be   = be_lfsr;

endmodule

`default_nettype wire

/* design/rc_types_pkg.sv */
//////////////////////////////
// Read checker types
// Command, beat, pattern and result structs, tracker states
//////////////////////////////
`default_nettype none

package rc_types_pkg;
   import rc_cfg_pkg::*;

   typedef struct packed {
      logic [ADDR_WIDTH-1:0] addr;
      logic [SIZE_WIDTH-1:0] burstcount;
   } rd_cmd_t;

   typedef struct packed {
      logic                  valid;
      logic [DATA_WIDTH-1:0] data;
   } rd_beat_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] data;
      logic [BE_WIDTH-1:0]   be;
   } expect_t;

   // Data fields are masked by the enabled lanes
   typedef struct packed {
      logic                  active;
      logic [DATA_WIDTH-1:0] pnf;
      logic [DATA_WIDTH-1:0] expected;
      logic [DATA_WIDTH-1:0] actual;
      logic [ADDR_WIDTH-1:0] addr;
   } cmp_result_t;

   typedef struct packed {
      logic [DATA_WIDTH-1:0] expected;
      logic [DATA_WIDTH-1:0] actual;
      logic [ADDR_WIDTH-1:0] addr;
   } fail_info_t;

   typedef enum logic {
      WAIT_CMD  = 1'b0,
      WAIT_DATA = 1'b1
   } tracker_state_t;

endpackage

`default_nettype wire

/* design/rc_cfg_pkg.sv */
//////////////////////////////
// Read checker configuration
// Widths, depths, LFSR seeds and taps
//////////////////////////////
`default_nettype none

package rc_cfg_pkg;

   // Data path
   localparam int DATA_WIDTH      = 32;
   localparam int BE_WIDTH        = 4;
   localparam int BYTE_SIZE       = DATA_WIDTH / BE_WIDTH;

   // Addressing, byte and word granularity
   localparam int ADDR_WIDTH      = 24;
   localparam int WORD_ADDR_WIDTH = ADDR_WIDTH - 2;
   localparam int SIZE_WIDTH      = 4;

   // Queue sizes
   localparam int CMD_FIFO_DEPTH  = 8;
   localparam int CMP_QUEUE_DEPTH = 16;
   localparam int CMP_COUNT_WIDTH = 5;
   localparam int STAT_WIDTH      = 32;

   // Pattern generators, must match the write side
   localparam logic [DATA_WIDTH-1:0] DATA_SEED = 32'h0F0F_3C65;
   localparam logic [DATA_WIDTH-1:0] DATA_TAPS = 32'h8020_0003;
   localparam logic [BE_WIDTH-1:0]   BE_SEED   = 4'b1001;
   localparam logic [BE_WIDTH-1:0]   BE_TAPS   = 4'b1100;

endpackage

`default_nettype wire
